// File: all.f
+incdir+src
src/spi_pkg.sv
src/spi_clk_div.sv
src/spi_master.sv
src/spi_access_ctrl.sv
src/spi_top.sv
bench/spi_properties.sv
bench/spi_slave_model.sv
bench/spi_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module spi_tb -Mdir obj_dir -o spi_sim
./obj_dir/spi_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation finished without failures"

// File: bench/spi_tb.sv
`timescale 1ns/1ps
`include "spi_defs.svh"
`default_nettype none

module spi_tb;

	import spi_pkg::*;

	localparam int MAX_ROWS   = 32;
	localparam int N_RAND     = 6;
	localparam int ROW_CYCLES = 40 * 2 * `SPI_CLK_DIV;

	logic                   CLK50MHZ;
	logic                   RST;
	logic                   acc_start;
	acc_op_t                acc_op;
	logic [`SPI_ADDR_W-1:0] acc_addr;
	logic [`SPI_DATA_W-1:0] acc_wdata;
	wire  [`SPI_DATA_W-1:0] acc_rdata;
	wire                    acc_done;
	wire                    busy;
	wire                    spi_sck;
	wire                    spi_cs;
	wire                    spi_mosi;
	wire                    spi_miso;

	// Stimulus table, one access per row
	acc_op_t                tbl_op    [MAX_ROWS];
	logic [`SPI_ADDR_W-1:0] tbl_addr  [MAX_ROWS];
	logic [`SPI_DATA_W-1:0] tbl_wdata [MAX_ROWS];
	logic [`SPI_DATA_W-1:0] tbl_exp   [MAX_ROWS];
	string                  tbl_name  [MAX_ROWS];
	bit                     tbl_drop  [MAX_ROWS];
	logic [`SPI_ADDR_W-1:0] tbl_daddr [MAX_ROWS];
	logic [`SPI_DATA_W-1:0] tbl_ddata [MAX_ROWS];
	int                     n_rows = 0;

	logic [`SPI_DATA_W-1:0] shadow   [128];
	logic [`SPI_ADDR_W-1:0] rnd_addr [N_RAND];
	logic [31:0]            rnd_state;
	logic [`SPI_DATA_W-1:0] last_rdata;
	bit                     have_rdata = 1'b0;
	logic                   cs_prev = 1'b1;
	int errors = 0;
	int n_pass = 0;
	int n_fail = 0;
	int done_cnt = 0;
	int cs_fall_cnt = 0;
	int cycle_cnt = 0;
	int timeout_cycles = 0;

	spi_top spi_top_i (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.acc_start (acc_start),
		.acc_op    (acc_op),
		.acc_addr  (acc_addr),
		.acc_wdata (acc_wdata),
		.acc_rdata (acc_rdata),
		.acc_done  (acc_done),
		.busy      (busy),
		.spi_sck   (spi_sck),
		.spi_cs    (spi_cs),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso)
	);

	spi_slave_model spi_slave_model_i (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	//////////////////////////////
	// Monitors and run limit
	//////////////////////////////

	always @(negedge CLK50MHZ) begin
		cs_prev <= spi_cs;
		if (!RST && acc_done)
			done_cnt <= done_cnt + 1;
		if (!RST && cs_prev && !spi_cs)
			cs_fall_cnt <= cs_fall_cnt + 1;
	end

	initial begin
		wait (timeout_cycles > 0);
		while (cycle_cnt < timeout_cycles) begin
			@(posedge CLK50MHZ);
			cycle_cnt++;
		end
		$display("Run stopped: tests still running after %0d clock cycles", cycle_cnt);
		$display("SOME TESTS FAILED");
		$finish;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_err(input string msg);
		$display("ERR %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("PASS %s", name);
			n_pass++;
		end else begin
			$display("FAIL %s (%0d errors)", name, errors - err_before);
			n_fail++;
		end
	endtask

	// Writes go to the shadow copy at table build time
	task automatic add_row(input acc_op_t op, input logic [6:0] addr, input logic [15:0] wdata,
			input logic [15:0] exp_data, input string name);
		tbl_op[n_rows]    = op;
		tbl_addr[n_rows]  = addr;
		tbl_wdata[n_rows] = wdata;
		tbl_exp[n_rows]   = exp_data;
		tbl_name[n_rows]  = name;
		tbl_drop[n_rows]  = 1'b0;
		if (op == ACC_WRITE)
			shadow[addr] = wdata;
		n_rows++;
	endtask

	// Extra write start issued while the last row is busy
	task automatic drop_start(input logic [6:0] addr, input logic [15:0] data);
		tbl_drop[n_rows-1]  = 1'b1;
		tbl_daddr[n_rows-1] = addr;
		tbl_ddata[n_rows-1] = data;
	endtask

	task automatic build_table();
		int a;
		int i;
		for (a = 0; a < 128; a++)
			shadow[a] = 16'(a) ^ 16'hA5A5;
		add_row(ACC_READ, 7'd0, 16'h0000, 16'hA5A5, "rd_reset_0");
		add_row(ACC_READ, 7'd1, 16'h0000, 16'hA5A4, "rd_reset_1");
		add_row(ACC_READ, 7'd64, 16'h0000, 16'hA5E5, "rd_reset_64");
		add_row(ACC_READ, 7'd127, 16'h0000, 16'hA5DA, "rd_reset_127");
		add_row(ACC_WRITE, 7'd5, 16'h1234, 16'h0000, "wr_5");
		add_row(ACC_WRITE, 7'd6, 16'hBEEF, 16'h0000, "wr_6");
		add_row(ACC_WRITE, 7'd127, 16'h0F0F, 16'h0000, "wr_127");
		add_row(ACC_READ, 7'd5, 16'h0000, 16'h1234, "rd_back_5");
		add_row(ACC_READ, 7'd6, 16'h0000, 16'hBEEF, "rd_back_6");
		add_row(ACC_READ, 7'd7, 16'h0000, 16'hA5A2, "rd_neighbor_7");
		add_row(ACC_READ, 7'd127, 16'h0000, 16'h0F0F, "rd_back_127");
		add_row(ACC_READ, 7'd4, 16'h0000, 16'hA5A1, "rd_neighbor_4");
		add_row(ACC_WRITE, 7'd10, 16'hCAFE, 16'h0000, "wr_10_busy_start");
		drop_start(7'd11, 16'hDEAD);
		add_row(ACC_READ, 7'd11, 16'h0000, 16'hA5AE, "rd_11_untouched");
		add_row(ACC_READ, 7'd10, 16'h0000, 16'hCAFE, "rd_10_busy_start");
		drop_start(7'd12, 16'h5555);
		add_row(ACC_READ, 7'd12, 16'h0000, 16'hA5A9, "rd_12_untouched");
		rnd_state = 32'h5d5d_8e1f;
		for (i = 0; i < N_RAND; i++) begin
			rnd_state   = next_rand(rnd_state);
			rnd_addr[i] = rnd_state[6:0];
			add_row(ACC_WRITE, rnd_state[6:0], rnd_state[31:16], 16'h0000,
				$sformatf("rand_wr_%0d", i));
		end
		for (i = 0; i < N_RAND; i++)
			add_row(ACC_READ, rnd_addr[i], 16'h0000, shadow[rnd_addr[i]],
				$sformatf("rand_rd_%0d", i));
		timeout_cycles = n_rows * ROW_CYCLES + 200;
	endtask

	task automatic check_idle(input int cycles);
		int err_before;
		err_before = errors;
		repeat (cycles) begin
			@(negedge CLK50MHZ);
			if (spi_cs !== 1'b1 || spi_sck !== 1'b0 || spi_mosi !== 1'b0)
				report_err($sformatf("idle pins cs=%b sck=%b mosi=%b", spi_cs, spi_sck, spi_mosi));
			if (busy !== 1'b0 || acc_done !== 1'b0)
				report_err($sformatf("idle status busy=%b acc_done=%b", busy, acc_done));
		end
		finish_test("idle_after_reset", err_before);
	endtask

	//////////////////////////////
	// One table row
	//////////////////////////////

	task automatic run_row(input int r);
		int waited;
		int err_before;
		bit seen;
		err_before = errors;
		acc_op     = tbl_op[r];
		acc_addr   = tbl_addr[r];
		acc_wdata  = tbl_wdata[r];
		acc_start  = 1'b1;
		waited     = 0;
		seen       = 1'b0;
		@(negedge CLK50MHZ);
		while (!seen && waited < ROW_CYCLES) begin
			if (busy !== 1'b1)
				report_err($sformatf("%s: busy low during access", tbl_name[r]));
			if (acc_done === 1'b1) begin
				seen = 1'b1;
			end else begin
				acc_start = tbl_drop[r] && waited == 8;
				if (acc_start) begin
					acc_op    = ACC_WRITE;
					acc_addr  = tbl_daddr[r];
					acc_wdata = tbl_ddata[r];
				end
				@(negedge CLK50MHZ);
				waited++;
			end
		end
		acc_start = 1'b0;
		if (!seen) begin
			$display("%s: acc_done never came within %0d cycles", tbl_name[r], ROW_CYCLES);
			errors++;
		end else if (tbl_op[r] == ACC_READ) begin
			if (acc_rdata !== tbl_exp[r])
				report_err($sformatf("%s: read data %h, expected %h",
					tbl_name[r], acc_rdata, tbl_exp[r]));
			last_rdata = tbl_exp[r];
			have_rdata = 1'b1;
		end else begin
			if (have_rdata && acc_rdata !== last_rdata)
				report_err($sformatf("%s: write changed acc_rdata to %h", tbl_name[r], acc_rdata));
		end
		@(negedge CLK50MHZ);
		if (busy !== 1'b0)
			report_err($sformatf("%s: busy still high after acc_done", tbl_name[r]));
		finish_test(tbl_name[r], err_before);
	endtask

	task automatic check_counts();
		int err_before;
		err_before = errors;
		if (done_cnt != n_rows)
			report_err($sformatf("acc_done pulses %0d, expected %0d", done_cnt, n_rows));
		if (cs_fall_cnt != n_rows)
			report_err($sformatf("CS falls %0d, expected %0d", cs_fall_cnt, n_rows));
		finish_test("frame_count", err_before);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		RST       = 1'b1;
		acc_start = 1'b0;
		acc_op    = ACC_WRITE;
		acc_addr  = '0;
		acc_wdata = '0;
		build_table();
		repeat (3) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		RST = 1'b0;
		check_idle(5);
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		check_counts();
		$display("Tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
		if (n_fail == 0 && errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/spi_slave_model.sv
`timescale 1ns/1ps
`include "spi_defs.svh"
`default_nettype none

module spi_slave_model (
	input  wire  CLK50MHZ,
	input  wire  RST,
	input  wire  spi_sck,
	input  wire  spi_cs,
	input  wire  spi_mosi,
	output logic spi_miso
);

	localparam int CNT_W     = $clog2(`SPI_FRAME_W) + 1;
	localparam int N_REGS    = 1 << `SPI_ADDR_W;
	// First rising edge of the data field
	localparam int DATA_EDGE = `SPI_FRAME_W - `SPI_DATA_W;

	logic [`SPI_DATA_W-1:0]  regs [0:N_REGS-1];
	logic [`SPI_FRAME_W-1:0] rx;
	logic [CNT_W-1:0]        edge_cnt;
	logic [`SPI_ADDR_W-1:0]  addr_q;
	logic                    rd_q;
	logic                    sck_q;
	logic                    cs_q;

	// SCK and CS are oversampled with the system clock
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			for (int i = 0; i < N_REGS; i++)
				regs[i] <= 16'(i) ^ 16'hA5A5;
			rx       <= '0;
			edge_cnt <= '0;
			addr_q   <= '0;
			rd_q     <= 1'b0;
			sck_q    <= 1'b0;
			cs_q     <= 1'b1;
			spi_miso <= 1'b0;
		end else begin
			sck_q <= spi_sck;
			cs_q  <= spi_cs;
			if (spi_cs && !cs_q) begin
				// Only a complete write frame updates the register
				if (!rd_q && edge_cnt == CNT_W'(`SPI_FRAME_W))
					regs[addr_q] <= rx[`SPI_DATA_W-1:0];
				edge_cnt <= '0;
				spi_miso <= 1'b0;
			end else if (!spi_cs && spi_sck && !sck_q) begin
				rx       <= {rx[`SPI_FRAME_W-2:0], spi_mosi};
				edge_cnt <= edge_cnt + 1'b1;
				// Eighth edge completes R/W bit and address
				if (edge_cnt == CNT_W'(`SPI_ADDR_W)) begin
					rd_q   <= rx[`SPI_ADDR_W-1];
					addr_q <= {rx[`SPI_ADDR_W-2:0], spi_mosi};
				end
				// Low count bits walk the data MSB first
				if (rd_q && edge_cnt >= CNT_W'(DATA_EDGE))
					spi_miso <= regs[addr_q][~edge_cnt[3:0]];
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/spi_properties.sv
`timescale 1ns/1ps
`default_nettype none

module spi_properties (
	input wire CLK50MHZ,
	input wire RST,
	input wire spi_sck,
	input wire spi_cs,
	input wire spi_mosi,
	input wire acc_done
);

	// SCK and MOSI stay quiet outside a frame
	idle_pins_low: assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_cs |-> (!spi_sck && !spi_mosi))
		else $error("spi_sck or spi_mosi high while spi_cs is high");

	done_single: assert property (@(posedge CLK50MHZ) disable iff (RST)
		acc_done |=> !acc_done)
		else $error("acc_done high for two cycles in a row");

	cs_after_reset: assert property (@(posedge CLK50MHZ)
		$fell(RST) |-> spi_cs)
		else $error("spi_cs low right after reset release");

endmodule

bind spi_top spi_properties spi_properties_i (
	.CLK50MHZ (CLK50MHZ),
	.RST      (RST),
	.spi_sck  (spi_sck),
	.spi_cs   (spi_cs),
	.spi_mosi (spi_mosi),
	.acc_done (acc_done)
);

`default_nettype wire

// File: src/spi_top.sv
`timescale 1ns/1ps
`include "spi_defs.svh"
`default_nettype none

module spi_top (
	input  wire                    CLK50MHZ,
	input  wire                    RST,
	// Host side
	input  wire                    acc_start,
	input  wire  spi_pkg::acc_op_t acc_op,
	input  wire  [`SPI_ADDR_W-1:0] acc_addr,
	input  wire  [`SPI_DATA_W-1:0] acc_wdata,
	output logic [`SPI_DATA_W-1:0] acc_rdata,
	output logic                   acc_done,
	output logic                   busy,
	// SPI pins
	output logic                   spi_sck,
	output logic                   spi_cs,
	output logic                   spi_mosi,
	input  wire                    spi_miso
);

	logic                    sck_phase;
	logic                    shift_pulse;
	logic                    xfer_start;
	logic                    xfer_done;
	logic [`SPI_FRAME_W-1:0] frame_tx;
	logic [`SPI_FRAME_W-1:0] frame_rx;

	spi_clk_div #(
		.DIV(`SPI_CLK_DIV)
	) spi_clk_div_i (
		.CLK50MHZ    (CLK50MHZ),
		.RST         (RST),
		.sck_phase   (sck_phase),
		.shift_pulse (shift_pulse)
	);

	spi_master #(
		.WIDTH(`SPI_FRAME_W)
	) spi_master_i (
		.CLK50MHZ    (CLK50MHZ),
		.RST         (RST),
		.sck_phase   (sck_phase),
		.shift_pulse (shift_pulse),
		.xfer_start  (xfer_start),
		.frame_tx    (frame_tx),
		.frame_rx    (frame_rx),
		.xfer_done   (xfer_done),
		.spi_sck     (spi_sck),
		.spi_cs      (spi_cs),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso)
	);

	spi_access_ctrl spi_access_ctrl_i (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.acc_start  (acc_start),
		.acc_op     (acc_op),
		.acc_addr   (acc_addr),
		.acc_wdata  (acc_wdata),
		.acc_rdata  (acc_rdata),
		.acc_done   (acc_done),
		.busy       (busy),
		.xfer_start (xfer_start),
		.frame_tx   (frame_tx),
		.frame_rx   (frame_rx),
		.xfer_done  (xfer_done)
	);

endmodule

`default_nettype wire

// File: src/spi_access_ctrl.sv
`timescale 1ns/1ps
`include "spi_defs.svh"
`default_nettype none

module spi_access_ctrl (
	input  wire                    CLK50MHZ,
	input  wire                    RST,
	// Host side
	input  wire                    acc_start,
	input  wire  spi_pkg::acc_op_t acc_op,
	input  wire  [`SPI_ADDR_W-1:0] acc_addr,
	input  wire  [`SPI_DATA_W-1:0] acc_wdata,
	output logic [`SPI_DATA_W-1:0] acc_rdata,
	output logic                   acc_done,
	output logic                   busy,
	// Frame engine side
	output logic                   xfer_start,
	output logic [`SPI_FRAME_W-1:0] frame_tx,
	input  wire  [`SPI_FRAME_W-1:0] frame_rx,
	input  wire                    xfer_done
);

	import spi_pkg::*;

	// Unused bits between address and data
	localparam int SPARE_W = `SPI_FRAME_W - 1 - `SPI_ADDR_W - `SPI_DATA_W;

	ctrl_state_t             state;
	acc_op_t                 op_q;
	logic                    accept;
	logic                    is_read;
	logic [`SPI_DATA_W-1:0]  tx_data;

	// Starts outside idle are dropped
	assign accept  = acc_start & (state == CTRL_IDLE);
	assign is_read = (acc_op == ACC_READ);

	// Read frames carry zero data
	assign tx_data = is_read ? '0 : acc_wdata;

	//////////////////////////////
	// Controller FSM
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= CTRL_IDLE;
		end else begin
			case (state)
				CTRL_IDLE:
					if (acc_start)
						state <= CTRL_LAUNCH;
				CTRL_LAUNCH:
					state <= CTRL_WAIT;
				CTRL_WAIT:
					if (xfer_done)
						state <= CTRL_FINISH;
				CTRL_FINISH:
					state <= CTRL_IDLE;
				default:
					state <= CTRL_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Command latch and frame build
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (accept) begin
			op_q     <= acc_op;
			frame_tx <= {is_read, acc_addr, {SPARE_W{1'b0}}, tx_data};
		end
	end

	// Reply data sits in the low bits of the received word
	always_ff @(posedge CLK50MHZ) begin
		if ((state == CTRL_WAIT) && xfer_done && (op_q == ACC_READ))
			acc_rdata <= frame_rx[`SPI_DATA_W-1:0];
	end

	//////////////////////////////
	// Status and handshake
	//////////////////////////////

	assign busy       = (state != CTRL_IDLE);
	assign xfer_start = (state == CTRL_LAUNCH);
	// One cycle after the engine's done
	assign acc_done   = (state == CTRL_FINISH);

endmodule

`default_nettype wire

// File: src/spi_master.sv
`timescale 1ns/1ps
`include "spi_defs.svh"
`default_nettype none

module spi_master #(
	parameter int WIDTH = `SPI_FRAME_W
) (
	input  wire              CLK50MHZ,
	input  wire              RST,
	// Phase inputs from the divider
	input  wire              sck_phase,
	input  wire              shift_pulse,
	// Word interface
	input  wire              xfer_start,
	input  wire  [WIDTH-1:0] frame_tx,
	output logic [WIDTH-1:0] frame_rx,
	output logic             xfer_done,
	// SPI pins
	output logic             spi_sck,
	output logic             spi_cs,
	output logic             spi_mosi,
	input  wire              spi_miso
);

	import spi_pkg::*;

	// Index counts up to WIDTH inclusive
	localparam int IDX_W = $clog2(WIDTH) + 1;

	xfer_state_t      state;
	logic [WIDTH-1:0] shreg;
	logic [IDX_W-1:0] bit_idx;
	logic             last_pulse;

	// Pulse that closes the frame and releases CS
	assign last_pulse = shift_pulse & (bit_idx == IDX_W'(WIDTH));

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= XFER_IDLE;
		end else begin
			case (state)
				XFER_IDLE:
					if (xfer_start)
						state <= XFER_SHIFT;
				XFER_SHIFT:
					if (last_pulse)
						state <= XFER_DONE;
				XFER_DONE:
					state <= XFER_IDLE;
				default:
					state <= XFER_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Bit index and pin drivers
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			bit_idx  <= '0;
			spi_cs   <= 1'b1;
			spi_mosi <= 1'b0;
		end else begin
			case (state)
				XFER_IDLE: begin
					bit_idx  <= '0;
					spi_cs   <= 1'b1;
					spi_mosi <= 1'b0;
				end
				XFER_SHIFT:
					if (shift_pulse) begin
						bit_idx <= bit_idx + 1'b1;
						// First pulse asserts CS, the extra one releases it
						spi_cs  <= last_pulse;
						if (last_pulse)
							spi_mosi <= 1'b0;
						else
							spi_mosi <= shreg[WIDTH-1];
					end
				default: begin
					spi_cs   <= 1'b1;
					spi_mosi <= 1'b0;
				end
			endcase
		end
	end

	//////////////////////////////
	// Shift register
	//////////////////////////////

	// Loads the outgoing word while idle; the bit taken in at the
	// first pulse falls off the top by the end of the frame
	always_ff @(posedge CLK50MHZ) begin
		case (state)
			XFER_IDLE:
				shreg <= frame_tx;
			XFER_SHIFT:
				if (shift_pulse)
					shreg <= {shreg[WIDTH-2:0], spi_miso};
			default:
				shreg <= shreg;
		endcase
	end

	assign frame_rx  = shreg;
	assign xfer_done = (state == XFER_DONE);

	// SCK idles low, runs only with CS asserted
	assign spi_sck = ~spi_cs & sck_phase;

endmodule

`default_nettype wire

// File: src/spi_clk_div.sv
`timescale 1ns/1ps
`default_nettype none

module spi_clk_div #(
	parameter int DIV = 2
) (
	input  wire  CLK50MHZ,
	input  wire  RST,
	output logic sck_phase,
	output logic shift_pulse
);

	// Counter must hold DIV-1, at least one bit
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic             cnt_wrap;

	assign cnt_wrap = (cnt == CNT_W'(DIV - 1));

	//////////////////////////////
	// Free running phase counter
	//////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt       <= '0;
			sck_phase <= 1'b0;
		end else begin
			if (cnt_wrap) begin
				cnt       <= '0;
				sck_phase <= ~sck_phase;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// High in the cycle whose closing edge drops sck_phase,
	// so the engine updates CS and MOSI on that same edge
	assign shift_pulse = cnt_wrap & sck_phase;

endmodule

`default_nettype wire

// File: src/spi_pkg.sv
`default_nettype none

package spi_pkg;

	//////////////////////////////
	// Host side access opcode
	//////////////////////////////

	// Encoding matches the read/write bit of the frame
	typedef enum logic {
		ACC_WRITE = 1'b0,
		ACC_READ  = 1'b1
	} acc_op_t;

	//////////////////////////////
	// FSM encodings
	//////////////////////////////

	// Frame engine
	typedef enum logic [1:0] {
		XFER_IDLE  = 2'd0,
		XFER_SHIFT = 2'd1,
		XFER_DONE  = 2'd2
	} xfer_state_t;

	// Access controller
	typedef enum logic [1:0] {
		CTRL_IDLE   = 2'd0,
		CTRL_LAUNCH = 2'd1,
		CTRL_WAIT   = 2'd2,
		CTRL_FINISH = 2'd3
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: src/spi_defs.svh
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

//////////////////////////////
// Frame layout
//////////////////////////////

// Full SPI word, MSB first on the wire
`define SPI_FRAME_W 32

// Peripheral register address
`define SPI_ADDR_W 7

// Peripheral register data
`define SPI_DATA_W 16

//////////////////////////////
// Serial clock
//////////////////////////////

// SCK half-period in CLK50MHZ cycles
`define SPI_CLK_DIV 2

`endif
